// File: src/ci_pkg.sv
package ci_pkg;

    localparam int WIN        = 13;   // Window edge in pixels.
    localparam int CENTER_LAG = 6;    // Newest column to center column.
    localparam int WIN_AREA   = 169;  // Pixels per window.
    localparam int PIX_W      = 8;
    localparam int SUM_W      = 16;   // Max window sum is 43095.

    // One image column with row 0 at the top of the band.
    typedef struct packed {
        logic [WIN-1:0][PIX_W-1:0] pix;
    } column_t;

    typedef struct packed {
        logic [SUM_W-1:0] sum;
        logic [PIX_W-1:0] center;
    } colsum_t;

    typedef struct packed {
        logic [SUM_W-1:0] sum;
        logic [PIX_W-1:0] center;
        logic             last_col;
        logic             last_band;
    } window_t;

    typedef struct packed {
        logic ci;
        logic band_done;
        logic frame_done;
    } ci_result_t;

endpackage

// File: src/column_sum.sv
`timescale 1ns/1ps

module column_sum (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_col_valid,
    input  ci_pkg::column_t  i_col,
    output logic             o_colsum_valid,
    output ci_pkg::colsum_t  o_colsum
);

    localparam int PAD_W = ci_pkg::SUM_W - ci_pkg::PIX_W;

    logic [ci_pkg::SUM_W-1:0] col_total;
    logic                     valid_q;
    ci_pkg::colsum_t          colsum_q;

    // Adder tree over the thirteen rows of the column.
    always_comb begin
        col_total = '0;
        for (int r = 0; r < ci_pkg::WIN; r++) begin
            col_total = col_total + {{PAD_W{1'b0}}, i_col.pix[r]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_col_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_col_valid) begin
            colsum_q.sum    <= col_total;
            colsum_q.center <= i_col.pix[ci_pkg::CENTER_LAG]; // Middle row.
        end
    end

    assign o_colsum_valid = valid_q;
    assign o_colsum       = colsum_q;

endmodule

// File: src/window_accumulator.sv
`timescale 1ns/1ps

module window_accumulator #(
    parameter int COLS = 15,
    parameter int ROWS = 15
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_colsum_valid,
    input  ci_pkg::colsum_t  i_colsum,
    output logic             o_win_valid,
    output ci_pkg::window_t  o_win
);

    localparam int BANDS  = ROWS - ci_pkg::WIN + 1;
    localparam int COL_W  = $clog2(COLS);
    localparam int BAND_W = (BANDS > 1) ? $clog2(BANDS) : 1;

    localparam logic [COL_W-1:0]  LAST_COL  = COL_W'(COLS - 1);
    localparam logic [COL_W-1:0]  FULL_COL  = COL_W'(ci_pkg::WIN - 1);
    localparam logic [COL_W-1:0]  EVICT_COL = COL_W'(ci_pkg::WIN);
    localparam logic [BAND_W-1:0] LAST_BAND = BAND_W'(BANDS - 1);

    logic [ci_pkg::SUM_W-1:0] sum_hist [ci_pkg::WIN];        // Index 0 is newest.
    logic [ci_pkg::PIX_W-1:0] cen_hist [ci_pkg::CENTER_LAG+1];
    logic [ci_pkg::SUM_W-1:0] win_sum;
    logic [ci_pkg::SUM_W-1:0] leaving;
    logic [COL_W-1:0]         col_cnt;
    logic [BAND_W-1:0]        band_cnt;
    logic                     win_valid_q;
    logic                     last_col_q;
    logic                     last_band_q;

    // Column that drops out of the window on this push.
    assign leaving = (col_cnt >= EVICT_COL) ? sum_hist[ci_pkg::WIN-1] : '0;

    always_ff @(posedge clk) begin
        if (i_colsum_valid) begin
            sum_hist[0] <= i_colsum.sum;
            for (int i = 1; i < ci_pkg::WIN; i++) begin
                sum_hist[i] <= sum_hist[i-1];
            end
            cen_hist[0] <= i_colsum.center;
            for (int i = 1; i <= ci_pkg::CENTER_LAG; i++) begin
                cen_hist[i] <= cen_hist[i-1];
            end
            if (col_cnt == '0) begin
                win_sum <= i_colsum.sum; // Fresh band.
            end else begin
                win_sum <= win_sum + i_colsum.sum - leaving;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt     <= '0;
            band_cnt    <= '0;
            win_valid_q <= 1'b0;
            last_col_q  <= 1'b0;
            last_band_q <= 1'b0;
        end else begin
            win_valid_q <= i_colsum_valid && (col_cnt >= FULL_COL);
            if (i_colsum_valid) begin
                last_col_q  <= (col_cnt == LAST_COL);
                last_band_q <= (band_cnt == LAST_BAND);
                if (col_cnt == LAST_COL) begin
                    col_cnt  <= '0;
                    band_cnt <= (band_cnt == LAST_BAND) ? '0 : band_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    assign o_win_valid     = win_valid_q;
    assign o_win.sum       = win_sum;
    assign o_win.center    = cen_hist[ci_pkg::CENTER_LAG]; // Middle of the window.
    assign o_win.last_col  = last_col_q;
    assign o_win.last_band = last_band_q;

endmodule

// File: src/center_compare.sv
`timescale 1ns/1ps

module center_compare (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_win_valid,
    input  ci_pkg::window_t    i_win,
    output logic               o_res_valid,
    output ci_pkg::ci_result_t o_res
);

    localparam int PAD_W = ci_pkg::SUM_W - ci_pkg::PIX_W;

    localparam logic [ci_pkg::SUM_W-1:0] AREA = ci_pkg::SUM_W'(ci_pkg::WIN_AREA);

    logic [ci_pkg::SUM_W-1:0] center_ext;
    logic [ci_pkg::SUM_W-1:0] scaled;
    logic                     ge_mean;
    logic                     res_valid_q;
    ci_pkg::ci_result_t       res_q;

    // 169 * 255 still fits in the sum width.
    assign center_ext = {{PAD_W{1'b0}}, i_win.center};
    assign scaled     = center_ext * AREA;
    assign ge_mean    = (scaled >= i_win.sum);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid_q <= 1'b0;
            res_q       <= '0;
        end else begin
            res_valid_q      <= i_win_valid;
            res_q.ci         <= i_win_valid && ge_mean;
            res_q.band_done  <= i_win_valid && i_win.last_col;
            res_q.frame_done <= i_win_valid && i_win.last_col && i_win.last_band;
        end
    end

    assign o_res_valid = res_valid_q;
    assign o_res       = res_q;

endmodule

// File: src/mrelbp_ci_r6.sv
`timescale 1ns/1ps

module mrelbp_ci_r6 #(
    parameter int COLS = 15,
    parameter int ROWS = 15
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_col_valid,
    input  ci_pkg::column_t    i_col,
    output logic               o_res_valid,
    output ci_pkg::ci_result_t o_res
);

    logic            colsum_valid;
    ci_pkg::colsum_t colsum;
    logic            win_valid;
    ci_pkg::window_t win;

    column_sum column_sum_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_col_valid    (i_col_valid),
        .i_col          (i_col),
        .o_colsum_valid (colsum_valid),
        .o_colsum       (colsum)
    );

    window_accumulator #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) window_accumulator_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_colsum_valid (colsum_valid),
        .i_colsum       (colsum),
        .o_win_valid    (win_valid),
        .o_win          (win)
    );

    center_compare center_compare_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_win_valid (win_valid),
        .i_win       (win),
        .o_res_valid (o_res_valid),
        .o_res       (o_res)
    );

endmodule

// File: bench/mrelbp_ci_assertions.sv
`timescale 1ns/1ps

module mrelbp_ci_assertions (
    input logic               clk,
    input logic               rst_n,
    input logic               i_col_valid,
    input logic               o_res_valid,
    input ci_pkg::ci_result_t o_res
);

    // Quiet while in reset and for one cycle after it.
    reset_quiet: assert property (@(posedge clk)
        (!$past(rst_n) || !$past(rst_n, 2)) |-> !o_res_valid)
        else $error("o_res_valid high during or right after reset");

    frame_in_band: assert property (@(posedge clk) disable iff (!rst_n)
        o_res.frame_done |-> o_res.band_done)
        else $error("frame_done without band_done");

    band_in_valid: assert property (@(posedge clk) disable iff (!rst_n)
        o_res.band_done |-> o_res_valid)
        else $error("band_done without o_res_valid");

    // Three register stages from column strobe to result.
    result_latency: assert property (@(posedge clk) disable iff (!rst_n)
        o_res_valid |-> $past(i_col_valid, 3))
        else $error("o_res_valid without a column strobe three cycles earlier");

endmodule

bind mrelbp_ci_r6 mrelbp_ci_assertions assertions_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_col_valid (i_col_valid),
    .o_res_valid (o_res_valid),
    .o_res       (o_res)
);

// File: bench/tb_mrelbp_ci.sv
`timescale 1ns/1ps

module tb_mrelbp_ci;

    localparam int    COLS       = 15;
    localparam int    ROWS       = 14;
    localparam int    BANDS      = ROWS - ci_pkg::WIN + 1;
    localparam int    PER_BAND   = COLS - ci_pkg::WIN + 1;  // Results per band.
    localparam int    FRAMES     = 2;                       // Second frame checks the wrap.
    localparam int    TIMEOUT    = 200;
    localparam string CASES_FILE = "bench/ci_cases.txt";

    logic               clk;
    logic               rst_n;
    logic               i_col_valid;
    ci_pkg::column_t    i_col;
    logic               o_res_valid;
    ci_pkg::ci_result_t o_res;

    ci_pkg::column_t    col_q [$];
    ci_pkg::ci_result_t exp_q [$];
    ci_pkg::ci_result_t res_q [$];
    int                 strobes_seen;
    logic [2:0]         strobe_hist;  // Strobes on the last three rising edges.

    mrelbp_ci_r6 #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_col_valid (i_col_valid),
        .i_col       (i_col),
        .o_res_valid (o_res_valid),
        .o_res       (o_res)
    );

    always #20 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic load_cases();
        int                 fd;
        int                 n;
        int                 ci_bit;
        int                 band_bit;
        int                 frame_bit;
        string              line;
        logic [7:0]         px [ci_pkg::WIN];
        ci_pkg::column_t    col;
        ci_pkg::ci_result_t res;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            stop_run("cannot open the case file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) == "c") begin
                    n = $sscanf(line, "c %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                px[0], px[1], px[2], px[3], px[4], px[5], px[6],
                                px[7], px[8], px[9], px[10], px[11], px[12]);
                    if (n != ci_pkg::WIN) begin
                        stop_run("malformed column line in the case file");
                    end else begin
                        for (int r = 0; r < ci_pkg::WIN; r++) begin
                            col.pix[r] = px[r];
                        end
                        col_q.push_back(col);
                    end
                end else if (line.len() > 1 && line.getc(0) == "r") begin
                    n = $sscanf(line, "r %d %d %d", ci_bit, band_bit, frame_bit);
                    if (n != 3) begin
                        stop_run("malformed result line in the case file");
                    end else begin
                        res.ci         = ci_bit[0];
                        res.band_done  = band_bit[0];
                        res.frame_done = frame_bit[0];
                        exp_q.push_back(res);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Strobes that must precede result n, counting from reset.
    function automatic int strobes_needed(input int n);
        int per_frame;
        int m;
        per_frame = BANDS * PER_BAND;
        m = n % per_frame;
        return (n / per_frame) * BANDS * COLS + (m / PER_BAND) * COLS
               + ci_pkg::WIN + (m % PER_BAND);
    endfunction

    task automatic drive_column(input ci_pkg::column_t col, input int gap);
        i_col_valid = 1'b1;
        i_col       = col;
        @(negedge clk);
        if (gap > 0) begin
            i_col_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic wait_results(input int target, input int band);
        int cycles;
        cycles = 0;
        while (res_q.size() < target && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (res_q.size() < target) begin
            stop_run($sformatf("result %0d of band %0d never arrived",
                               res_q.size() % PER_BAND, band));
        end
    endtask

    task automatic check_result(input int idx, input ci_pkg::ci_result_t exp,
                                input ci_pkg::ci_result_t act);
        if (act !== exp) begin
            stop_run($sformatf(
                "error t=%0t o_res[%0d] {ci,band_done,frame_done}: expected %b got %b",
                $time, idx, exp, act));
        end
    endtask

    task automatic check_count(input int band, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("error t=%0t result count of band %0d: expected %0d got %0d",
                               $time, band, exp, act));
        end
    endtask

    // Column strobes as the DUT samples them.
    always @(posedge clk) begin
        strobe_hist = {strobe_hist[1:0], rst_n && i_col_valid};
        if (rst_n && i_col_valid) begin
            strobes_seen++;
        end
    end

    // Each result comes three edges after the strobe of its own column.
    always @(negedge clk) begin
        if (rst_n && o_res_valid) begin
            if (!strobe_hist[2] || strobes_seen - strobe_hist[1] - strobe_hist[0]
                    != strobes_needed(res_q.size())) begin
                stop_run($sformatf("result %0d did not follow column strobe %0d by three cycles",
                                   res_q.size(), strobes_needed(res_q.size())));
            end else begin
                res_q.push_back(o_res);
            end
        end
    end

    initial begin
        int gap;
        int base;
        clk          = 1'b0;
        rst_n        = 1'b0;
        i_col_valid  = 1'b0;
        i_col        = '0;
        strobes_seen = 0;
        strobe_hist  = '0;
        void'($urandom(32'hf062_3d00));
        load_cases();
        if (col_q.size() != BANDS * COLS || exp_q.size() != BANDS * PER_BAND) begin
            stop_run("case file does not hold a whole frame of columns and results");
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int f = 0; f < FRAMES; f++) begin
            for (int b = 0; b < BANDS; b++) begin
                for (int c = 0; c < COLS; c++) begin
                    gap = $urandom % 4;
                    drive_column(col_q[b * COLS + c], gap);
                end
                i_col_valid = 1'b0;
                base = (f * BANDS + b) * PER_BAND;
                wait_results(base + PER_BAND, b);
                repeat (4) @(posedge clk); // Catch any extra result.
                check_count(b, PER_BAND, res_q.size() - base);
                for (int k = 0; k < PER_BAND; k++) begin
                    check_result(base + k, exp_q[b * PER_BAND + k], res_q[base + k]);
                end
                @(negedge clk);
            end
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: src.f
src/ci_pkg.sv
src/column_sum.sv
src/window_accumulator.sv
src/center_compare.sv
src/mrelbp_ci_r6.sv
bench/mrelbp_ci_assertions.sv
bench/tb_mrelbp_ci.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mrelbp_ci
FILELIST  := src.f
OBJ_DIR   := obj_dir
CASES     := bench/ci_cases.txt

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(CASES)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/ci_cases.txt
# c: one column of the band, thirteen hex pixels, row 0 first
# r: expected result in order, ci band_done frame_done
# band 0
c 70 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 12 10 10 10 10 10 10
c 10 10 10 10 10 10 11 10 10 10 10 10 10
c 10 10 10 10 10 10 ff 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
# band 1
c 42 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 10
c 10 10 10 10 10 10 10 10 10 10 10 10 11
# band 0 results
r 1 0 0
r 0 0 0
r 1 1 0
# band 1 results
r 0 0 0
r 1 0 0
r 0 1 1
